//--- rtl/zynq_shell_pkg.sv
package zynq_shell_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////

  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_ADDR_W = 10;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

  // top two address bits pick the region, value 3 is unmapped
  typedef enum logic [1:0] {
    REGION_CTRL = 2'd0,
    REGION_STAT = 2'd1,
    REGION_FIFO = 2'd2
  } region_e;

  // fifo access kind, value 3 is unmapped
  typedef enum logic [1:0] {
    KIND_DATA = 2'd0,
    KIND_FREE = 2'd1,
    KIND_OCC  = 2'd2
  } fifo_kind_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axil_resp_e;

  ////////////////////////////////////////////////////////////
  // address views
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    region_e    region;
    logic [1:0] unused;
    logic [3:0] idx;
    logic [1:0] byte_ofs;
  } reg_addr_t;

  typedef struct packed {
    region_e    region;
    logic [1:0] unused;
    fifo_kind_e kind;
    logic [1:0] idx;
    logic [1:0] byte_ofs;
  } fifo_addr_t;

  typedef union packed {
    reg_addr_t  r;
    fifo_addr_t f;
  } axil_addr_u;

endpackage

//--- rtl/shell_access_if.sv
interface shell_access_if import zynq_shell_pkg::*; ();

  logic                   req;
  logic                   we;
  axil_addr_u             addr;
  logic [AXIL_DATA_W-1:0] wdata;
  logic [AXIL_STRB_W-1:0] wstrb;

  // returned in the same cycle as req
  logic [AXIL_DATA_W-1:0] rdata;
  logic                   err;

  modport front (
    output req, we, addr, wdata, wstrb,
    input  rdata, err
  );

  modport bank (
    input  req, we, addr, wdata, wstrb,
    output rdata, err
  );

endinterface

//--- rtl/shell_fifo.sv
module shell_fifo import zynq_shell_pkg::*; #(
  parameter  int DEPTH = 4,
  localparam int CNT_W = $clog2(DEPTH + 1)
) (
  input  logic                   aclk,
  input  logic                   rst_n_i,
  input  logic                   push_i,
  input  logic [AXIL_DATA_W-1:0] data_i,
  output logic                   full_o,
  input  logic                   pop_i,
  output logic [AXIL_DATA_W-1:0] data_o,
  output logic                   empty_o,
  output logic [CNT_W-1:0]       count_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [AXIL_DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]       count_q;

  always_ff @(posedge aclk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (push_i) mem[wr_ptr_q] <= data_i;
  end

  // head is visible without a pop
  assign data_o  = mem[rd_ptr_q];
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;

endmodule

//--- rtl/csr_bank.sv
module csr_bank import zynq_shell_pkg::*; #(
  parameter int NUM_CTRL_REGS = 5,
  parameter int NUM_STAT_REGS = 2
) (
  input  logic                                       aclk,
  input  logic                                       rst_n_i,
  shell_access_if.bank                               acc,
  output logic [NUM_CTRL_REGS-1:0][AXIL_DATA_W-1:0] ctrl_data_o,
  output logic [NUM_CTRL_REGS-1:0]                   ctrl_new_o,
  input  logic [NUM_STAT_REGS-1:0][AXIL_DATA_W-1:0] stat_data_i
);

  logic [NUM_CTRL_REGS-1:0][AXIL_DATA_W-1:0] ctrl_q;
  logic [NUM_CTRL_REGS-1:0]                   new_q;
  logic [NUM_CTRL_REGS-1:0]                   wr_sel;

  always_comb begin
    for (int i = 0; i < NUM_CTRL_REGS; i++) begin
      wr_sel[i] = acc.req && acc.we && (acc.addr.r.region == REGION_CTRL) &&
                  (acc.addr.r.idx == 4'(i));
    end
  end

  // byte-wise update, new pulse follows the write edge
  always_ff @(posedge aclk) begin
    if (!rst_n_i) begin
      ctrl_q <= '0;
      new_q  <= '0;
    end else begin
      for (int i = 0; i < NUM_CTRL_REGS; i++) begin
        new_q[i] <= wr_sel[i];
        for (int b = 0; b < AXIL_STRB_W; b++) begin
          if (wr_sel[i] && acc.wstrb[b]) begin
            ctrl_q[i][8*b +: 8] <= acc.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign ctrl_data_o = ctrl_q;
  assign ctrl_new_o  = new_q;

  // read side, control or status set
  always_comb begin
    acc.rdata = '0;
    if (acc.addr.r.region == REGION_STAT) begin
      for (int i = 0; i < NUM_STAT_REGS; i++) begin
        if (acc.addr.r.idx == 4'(i)) acc.rdata = stat_data_i[i];
      end
    end else begin
      for (int i = 0; i < NUM_CTRL_REGS; i++) begin
        if (acc.addr.r.idx == 4'(i)) acc.rdata = ctrl_q[i];
      end
    end
  end

  // registers always accept
  assign acc.err = 1'b0;

endmodule

//--- rtl/fifo_bank.sv
module fifo_bank import zynq_shell_pkg::*; #(
  parameter int NUM_FIFOS  = 2,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                                   aclk,
  input  logic                                   rst_n_i,
  shell_access_if.bank                           acc,
  output logic [NUM_FIFOS-1:0][AXIL_DATA_W-1:0] ps_to_pl_data_o,
  output logic [NUM_FIFOS-1:0]                   ps_to_pl_v_o,
  input  logic [NUM_FIFOS-1:0]                   ps_to_pl_yumi_i,
  input  logic [NUM_FIFOS-1:0][AXIL_DATA_W-1:0] pl_to_ps_data_i,
  input  logic [NUM_FIFOS-1:0]                   pl_to_ps_v_i,
  output logic [NUM_FIFOS-1:0]                   pl_to_ps_ready_o
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [NUM_FIFOS-1:0]                   p2l_push, p2l_full, p2l_empty;
  logic [NUM_FIFOS-1:0][CNT_W-1:0]        p2l_count;
  logic [NUM_FIFOS-1:0]                   l2p_push, l2p_pop, l2p_full, l2p_empty;
  logic [NUM_FIFOS-1:0][CNT_W-1:0]        l2p_count;
  logic [NUM_FIFOS-1:0][AXIL_DATA_W-1:0] l2p_data;

  for (genvar i = 0; i < NUM_FIFOS; i++) begin : g_fifo
    logic hit;

    assign hit = acc.req && (acc.addr.f.kind == KIND_DATA) && (acc.addr.f.idx == 2'(i));

    // full and empty accesses are dropped here and flagged below
    assign p2l_push[i] = hit & acc.we & ~p2l_full[i];
    assign l2p_pop[i]  = hit & ~acc.we & ~l2p_empty[i];
    assign l2p_push[i] = pl_to_ps_v_i[i] & ~l2p_full[i];

    shell_fifo #(.DEPTH(FIFO_DEPTH)) u_ps_to_pl (
      .aclk    (aclk),
      .rst_n_i (rst_n_i),
      .push_i  (p2l_push[i]),
      .data_i  (acc.wdata),
      .full_o  (p2l_full[i]),
      .pop_i   (ps_to_pl_yumi_i[i]),
      .data_o  (ps_to_pl_data_o[i]),
      .empty_o (p2l_empty[i]),
      .count_o (p2l_count[i])
    );

    shell_fifo #(.DEPTH(FIFO_DEPTH)) u_pl_to_ps (
      .aclk    (aclk),
      .rst_n_i (rst_n_i),
      .push_i  (l2p_push[i]),
      .data_i  (pl_to_ps_data_i[i]),
      .full_o  (l2p_full[i]),
      .pop_i   (l2p_pop[i]),
      .data_o  (l2p_data[i]),
      .empty_o (l2p_empty[i]),
      .count_o (l2p_count[i])
    );

    assign ps_to_pl_v_o[i]     = ~p2l_empty[i];
    assign pl_to_ps_ready_o[i] = ~l2p_full[i];
  end

  // data pops and count reads
  always_comb begin
    acc.rdata = '0;
    acc.err   = 1'b0;
    for (int i = 0; i < NUM_FIFOS; i++) begin
      if (acc.addr.f.idx == 2'(i)) begin
        case (acc.addr.f.kind)
          KIND_DATA: begin
            acc.rdata = l2p_data[i];
            acc.err   = acc.we ? p2l_full[i] : l2p_empty[i];
          end
          KIND_FREE: acc.rdata = AXIL_DATA_W'(FIFO_DEPTH) - AXIL_DATA_W'(p2l_count[i]);
          KIND_OCC:  acc.rdata = AXIL_DATA_W'(l2p_count[i]);
          default:   acc.rdata = '0;
        endcase
      end
    end
  end

endmodule

//--- rtl/axil_front.sv
module axil_front import zynq_shell_pkg::*; #(
  parameter int NUM_CTRL_REGS = 5,
  parameter int NUM_STAT_REGS = 2,
  parameter int NUM_FIFOS     = 2
) (
  input  logic                   aclk,
  input  logic                   rst_n_i,

  input  logic [AXIL_ADDR_W-1:0] s_axil_awaddr_i,
  input  logic                   s_axil_awvalid_i,
  output logic                   s_axil_awready_o,
  input  logic [AXIL_DATA_W-1:0] s_axil_wdata_i,
  input  logic [AXIL_STRB_W-1:0] s_axil_wstrb_i,
  input  logic                   s_axil_wvalid_i,
  output logic                   s_axil_wready_o,
  output logic [1:0]             s_axil_bresp_o,
  output logic                   s_axil_bvalid_o,
  input  logic                   s_axil_bready_i,
  input  logic [AXIL_ADDR_W-1:0] s_axil_araddr_i,
  input  logic                   s_axil_arvalid_i,
  output logic                   s_axil_arready_o,
  output logic [AXIL_DATA_W-1:0] s_axil_rdata_o,
  output logic [1:0]             s_axil_rresp_o,
  output logic                   s_axil_rvalid_o,
  input  logic                   s_axil_rready_i,

  shell_access_if.front          ctrl_acc,
  shell_access_if.front          fifo_acc
);

  logic                   bvalid_q, rvalid_q;
  axil_resp_e             bresp_q, rresp_q;
  logic [AXIL_DATA_W-1:0] rdata_q;

  logic                   wr_hs, rd_hs, acc_active;
  axil_addr_u             acc_addr;
  logic                   mapped, ctrl_sel, fifo_sel;
  logic                   bank_err;
  logic [AXIL_DATA_W-1:0] bank_rdata, rdata_d;
  axil_resp_e             resp_d;

  ////////////////////////////////////////////////////////////
  // handshakes, writes win over reads
  ////////////////////////////////////////////////////////////

  assign wr_hs = s_axil_awvalid_i & s_axil_wvalid_i & ~bvalid_q;
  assign rd_hs = s_axil_arvalid_i & ~rvalid_q & ~wr_hs;

  assign s_axil_awready_o = wr_hs;
  assign s_axil_wready_o  = wr_hs;
  assign s_axil_arready_o = rd_hs;

  assign acc_active = wr_hs | rd_hs;
  assign acc_addr   = wr_hs ? s_axil_awaddr_i : s_axil_araddr_i;

  // address map check
  always_comb begin
    mapped = 1'b0;
    case (acc_addr.r.region)
      REGION_CTRL: mapped = int'(acc_addr.r.idx) < NUM_CTRL_REGS;
      REGION_STAT: mapped = !wr_hs && int'(acc_addr.r.idx) < NUM_STAT_REGS;
      REGION_FIFO: begin
        if (int'(acc_addr.f.idx) < NUM_FIFOS) begin
          // count kinds are read only
          mapped = (acc_addr.f.kind == KIND_DATA) ||
                   (!wr_hs && (acc_addr.f.kind == KIND_FREE || acc_addr.f.kind == KIND_OCC));
        end
      end
      default: mapped = 1'b0;
    endcase
  end

  assign ctrl_sel = (acc_addr.r.region == REGION_CTRL) || (acc_addr.r.region == REGION_STAT);
  assign fifo_sel = (acc_addr.r.region == REGION_FIFO);

  assign ctrl_acc.req   = acc_active & mapped & ctrl_sel;
  assign ctrl_acc.we    = wr_hs;
  assign ctrl_acc.addr  = acc_addr;
  assign ctrl_acc.wdata = s_axil_wdata_i;
  assign ctrl_acc.wstrb = s_axil_wstrb_i;

  assign fifo_acc.req   = acc_active & mapped & fifo_sel;
  assign fifo_acc.we    = wr_hs;
  assign fifo_acc.addr  = acc_addr;
  assign fifo_acc.wdata = s_axil_wdata_i;
  assign fifo_acc.wstrb = s_axil_wstrb_i;

  ////////////////////////////////////////////////////////////
  // merge bank results
  ////////////////////////////////////////////////////////////

  assign bank_err   = fifo_sel ? fifo_acc.err : ctrl_acc.err;
  assign bank_rdata = fifo_sel ? fifo_acc.rdata : ctrl_acc.rdata;

  assign resp_d  = !mapped ? RESP_DECERR : (bank_err ? RESP_SLVERR : RESP_OKAY);
  // rejected or unmapped reads return zero
  assign rdata_d = (mapped && !bank_err) ? bank_rdata : '0;

  always_ff @(posedge aclk) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (s_axil_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (s_axil_rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (wr_hs) begin
      bresp_q <= resp_d;
    end
    if (rd_hs) begin
      rresp_q <= resp_d;
      rdata_q <= rdata_d;
    end
  end

  assign s_axil_bvalid_o = bvalid_q;
  assign s_axil_bresp_o  = bresp_q;
  assign s_axil_rvalid_o = rvalid_q;
  assign s_axil_rresp_o  = rresp_q;
  assign s_axil_rdata_o  = rdata_q;

endmodule

//--- rtl/zynq_pl_shell.sv
module zynq_pl_shell import zynq_shell_pkg::*; #(
  parameter int NUM_CTRL_REGS = 5,
  parameter int NUM_STAT_REGS = 2,
  parameter int NUM_FIFOS     = 2,
  parameter int FIFO_DEPTH    = 4
) (
  input  logic                                       aclk,
  input  logic                                       rst_n_i,

  // axi-lite slave
  input  logic [AXIL_ADDR_W-1:0]                     s_axil_awaddr_i,
  input  logic                                       s_axil_awvalid_i,
  output logic                                       s_axil_awready_o,
  input  logic [AXIL_DATA_W-1:0]                     s_axil_wdata_i,
  input  logic [AXIL_STRB_W-1:0]                     s_axil_wstrb_i,
  input  logic                                       s_axil_wvalid_i,
  output logic                                       s_axil_wready_o,
  output logic [1:0]                                 s_axil_bresp_o,
  output logic                                       s_axil_bvalid_o,
  input  logic                                       s_axil_bready_i,
  input  logic [AXIL_ADDR_W-1:0]                     s_axil_araddr_i,
  input  logic                                       s_axil_arvalid_i,
  output logic                                       s_axil_arready_o,
  output logic [AXIL_DATA_W-1:0]                     s_axil_rdata_o,
  output logic [1:0]                                 s_axil_rresp_o,
  output logic                                       s_axil_rvalid_o,
  input  logic                                       s_axil_rready_i,

  // registers
  output logic [NUM_CTRL_REGS-1:0][AXIL_DATA_W-1:0] ctrl_data_o,
  output logic [NUM_CTRL_REGS-1:0]                   ctrl_new_o,
  input  logic [NUM_STAT_REGS-1:0][AXIL_DATA_W-1:0] stat_data_i,

  // fifos
  output logic [NUM_FIFOS-1:0][AXIL_DATA_W-1:0]     ps_to_pl_data_o,
  output logic [NUM_FIFOS-1:0]                       ps_to_pl_v_o,
  input  logic [NUM_FIFOS-1:0]                       ps_to_pl_yumi_i,
  input  logic [NUM_FIFOS-1:0][AXIL_DATA_W-1:0]     pl_to_ps_data_i,
  input  logic [NUM_FIFOS-1:0]                       pl_to_ps_v_i,
  output logic [NUM_FIFOS-1:0]                       pl_to_ps_ready_o
);

  shell_access_if ctrl_acc ();
  shell_access_if fifo_acc ();

  axil_front #(
    .NUM_CTRL_REGS (NUM_CTRL_REGS),
    .NUM_STAT_REGS (NUM_STAT_REGS),
    .NUM_FIFOS     (NUM_FIFOS)
  ) u_front (
    .aclk             (aclk),
    .rst_n_i          (rst_n_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .ctrl_acc         (ctrl_acc.front),
    .fifo_acc         (fifo_acc.front)
  );

  csr_bank #(
    .NUM_CTRL_REGS (NUM_CTRL_REGS),
    .NUM_STAT_REGS (NUM_STAT_REGS)
  ) u_csr (
    .aclk        (aclk),
    .rst_n_i     (rst_n_i),
    .acc         (ctrl_acc.bank),
    .ctrl_data_o (ctrl_data_o),
    .ctrl_new_o  (ctrl_new_o),
    .stat_data_i (stat_data_i)
  );

  fifo_bank #(
    .NUM_FIFOS  (NUM_FIFOS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifos (
    .aclk             (aclk),
    .rst_n_i          (rst_n_i),
    .acc              (fifo_acc.bank),
    .ps_to_pl_data_o  (ps_to_pl_data_o),
    .ps_to_pl_v_o     (ps_to_pl_v_o),
    .ps_to_pl_yumi_i  (ps_to_pl_yumi_i),
    .pl_to_ps_data_i  (pl_to_ps_data_i),
    .pl_to_ps_v_i     (pl_to_ps_v_i),
    .pl_to_ps_ready_o (pl_to_ps_ready_o)
  );

endmodule

//--- bench/zynq_pl_shell_chk.sv
module zynq_pl_shell_chk import zynq_shell_pkg::*; #(
  parameter int NUM_CTRL_REGS = 5,
  parameter int NUM_FIFOS     = 2
) (
  input logic                                   aclk,
  input logic                                   rst_n_i,
  input logic                                   s_axil_awready_o,
  input logic                                   s_axil_wready_o,
  input logic                                   s_axil_arready_o,
  input logic                                   s_axil_bvalid_o,
  input logic                                   s_axil_bready_i,
  input logic [1:0]                             s_axil_bresp_o,
  input logic                                   s_axil_rvalid_o,
  input logic                                   s_axil_rready_i,
  input logic [1:0]                             s_axil_rresp_o,
  input logic [AXIL_DATA_W-1:0]                 s_axil_rdata_o,
  input logic [NUM_CTRL_REGS-1:0]               ctrl_new_o,
  input logic [NUM_FIFOS-1:0]                   ps_to_pl_v_o,
  input logic [NUM_FIFOS-1:0]                   ps_to_pl_yumi_i,
  input logic [NUM_FIFOS-1:0][AXIL_DATA_W-1:0] ps_to_pl_data_o,
  input logic [NUM_FIFOS-1:0]                   pl_to_ps_ready_o
);

  int fail_count = 0;

  //////////////////////////////////////////////////////////////
  // axi-lite response channels
  //////////////////////////////////////////////////////////////

  a_bvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n_i)
    s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o && $stable(s_axil_bresp_o))
    else begin
      fail_count++;
      $error("bvalid dropped or bresp changed before bready");
    end

  a_rvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n_i)
    s_axil_rvalid_o && !s_axil_rready_i |=>
      s_axil_rvalid_o && $stable(s_axil_rresp_o) && $stable(s_axil_rdata_o))
    else begin
      fail_count++;
      $error("rvalid dropped or read response changed before rready");
    end

  // state right after a reset cycle
  a_reset_state: assert property (@(posedge aclk)
    !rst_n_i |=> !s_axil_awready_o && !s_axil_wready_o && !s_axil_arready_o &&
      !s_axil_bvalid_o && !s_axil_rvalid_o && ctrl_new_o == '0 &&
      ps_to_pl_v_o == '0 && &pl_to_ps_ready_o)
    else begin
      fail_count++;
      $error("outputs not idle after reset");
    end

  for (genvar i = 0; i < NUM_CTRL_REGS; i++) begin : g_new
    a_new_pulse: assert property (@(posedge aclk) disable iff (!rst_n_i)
      ctrl_new_o[i] |=> !ctrl_new_o[i])
      else begin
        fail_count++;
        $error("ctrl_new_o[%0d] longer than one cycle", i);
      end
  end

  for (genvar i = 0; i < NUM_FIFOS; i++) begin : g_p2l
    a_head_hold: assert property (@(posedge aclk) disable iff (!rst_n_i)
      ps_to_pl_v_o[i] && !ps_to_pl_yumi_i[i] |=>
        ps_to_pl_v_o[i] && $stable(ps_to_pl_data_o[i]))
      else begin
        fail_count++;
        $error("ps_to_pl head %0d changed without yumi", i);
      end
  end

endmodule

bind zynq_pl_shell zynq_pl_shell_chk #(
  .NUM_CTRL_REGS (NUM_CTRL_REGS),
  .NUM_FIFOS     (NUM_FIFOS)
) u_chk (.*);

//--- bench/tb_zynq_pl_shell.sv
module tb_zynq_pl_shell import zynq_shell_pkg::*; ();

  localparam int NUM_CTRL = 5;
  localparam int NUM_STAT = 2;
  localparam int NUM_F    = 2;
  localparam int DEPTH    = 4;
  localparam logic [31:0] SEED = 32'h9cfd9264;
  // the tests take roughly 1500 cycles
  localparam int MAX_CYCLES = 4000;

  logic                             aclk, rst_n_i;
  logic [9:0]                       s_axil_awaddr_i, s_axil_araddr_i;
  logic                             s_axil_awvalid_i, s_axil_wvalid_i, s_axil_arvalid_i;
  logic [31:0]                      s_axil_wdata_i, s_axil_rdata_o;
  logic [3:0]                       s_axil_wstrb_i;
  logic                             s_axil_bready_i, s_axil_rready_i;
  logic                             s_axil_awready_o, s_axil_wready_o, s_axil_arready_o;
  logic                             s_axil_bvalid_o, s_axil_rvalid_o;
  logic [1:0]                       s_axil_bresp_o, s_axil_rresp_o;
  logic [NUM_CTRL-1:0][31:0]        ctrl_data_o;
  logic [NUM_CTRL-1:0]              ctrl_new_o;
  logic [NUM_STAT-1:0][31:0]        stat_data_i;
  logic [NUM_F-1:0][31:0]           ps_to_pl_data_o, pl_to_ps_data_i;
  logic [NUM_F-1:0]                 ps_to_pl_v_o, ps_to_pl_yumi_i;
  logic [NUM_F-1:0]                 pl_to_ps_v_i, pl_to_ps_ready_o;

  logic [31:0] ctrl_model [NUM_CTRL];
  logic [31:0] p2l_model [NUM_F][$];
  logic [31:0] l2p_model [NUM_F][$];
  logic [31:0] bg_state, data_state;
  logic [31:0] b_wait_state, r_wait_state;
  logic        yumi_en, push_en;
  int          cycle_count = 0;

  zynq_pl_shell dut (.*);

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [9:0] reg_addr(input logic [1:0] region, input int idx);
    return {region, 2'b00, 4'(idx), 2'b00};
  endfunction

  function automatic logic [9:0] fifo_addr(input logic [1:0] kind, input int idx);
    return {2'd2, 2'b00, kind, 2'(idx), 2'b00};
  endfunction

  function automatic int p2l_pending();
    int n = 0;
    for (int i = 0; i < NUM_F; i++) n += p2l_model[i].size();
    return n;
  endfunction

  task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    a_value: assert (got === exp) else begin
      $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    a_cond: assert (cond) else begin
      $display("Check failed at %0t: %s", $time, what);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // axi-lite master tasks
  ////////////////////////////////////////////////////////////

  task automatic axil_write(input logic [9:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp,
                            output logic [NUM_CTRL-1:0] new_seen);
    @(negedge aclk);
    s_axil_awaddr_i  = addr;
    s_axil_wdata_i   = data;
    s_axil_wstrb_i   = strb;
    s_axil_awvalid_i = 1'b1;
    s_axil_wvalid_i  = 1'b1;
    do @(posedge aclk); while (!s_axil_awready_o);
    expect_true(s_axil_wready_o, "wready low while awready is high");
    @(negedge aclk);
    s_axil_awvalid_i = 1'b0;
    s_axil_wvalid_i  = 1'b0;
    while (!s_axil_bvalid_o) @(negedge aclk);
    resp         = s_axil_bresp_o;
    new_seen     = ctrl_new_o;
    // bready may lag bvalid by up to three cycles
    b_wait_state = lcg(b_wait_state);
    repeat (b_wait_state[21:20]) @(negedge aclk);
    s_axil_bready_i = 1'b1;
    @(negedge aclk);
    s_axil_bready_i = 1'b0;
  endtask

  task automatic axil_read(input logic [9:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    @(negedge aclk);
    s_axil_araddr_i  = addr;
    s_axil_arvalid_i = 1'b1;
    do @(posedge aclk); while (!s_axil_arready_o);
    @(negedge aclk);
    s_axil_arvalid_i = 1'b0;
    while (!s_axil_rvalid_o) @(negedge aclk);
    data         = s_axil_rdata_o;
    resp         = s_axil_rresp_o;
    r_wait_state = lcg(r_wait_state);
    repeat (r_wait_state[21:20]) @(negedge aclk);
    s_axil_rready_i = 1'b1;
    @(negedge aclk);
    s_axil_rready_i = 1'b0;
  endtask

  task automatic write_expect(input logic [9:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp);
    logic [1:0]          resp;
    logic [NUM_CTRL-1:0] new_seen;
    axil_write(addr, data, 4'hf, resp, new_seen);
    expect_eq(resp, exp_resp, $sformatf("bresp for write to %h", addr));
  endtask

  task automatic read_expect(input logic [9:0] addr, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, data, resp);
    expect_eq(resp, exp_resp, $sformatf("rresp for read of %h", addr));
    expect_eq(data, exp_data, $sformatf("rdata for read of %h", addr));
  endtask

  ////////////////////////////////////////////////////////////
  // fifo side stimulus and models
  ////////////////////////////////////////////////////////////

  // random yumi and pl-to-ps pushes
  always @(negedge aclk) begin
    for (int i = 0; i < NUM_F; i++) begin
      bg_state = lcg(bg_state);
      ps_to_pl_yumi_i[i] = yumi_en && ps_to_pl_v_o[i] && bg_state[16];
      pl_to_ps_v_i[i]    = push_en && bg_state[19];
      bg_state = lcg(bg_state);
      pl_to_ps_data_i[i] = bg_state;
    end
  end

  always @(posedge aclk) begin
    if (rst_n_i) begin
      for (int i = 0; i < NUM_F; i++) begin
        if (ps_to_pl_v_o[i] && ps_to_pl_yumi_i[i]) begin
          expect_true(p2l_model[i].size() > 0, "ps-to-pl fifo popped a word never written");
          expect_eq(ps_to_pl_data_o[i], p2l_model[i].pop_front(), "ps_to_pl_data_o");
        end
        if (pl_to_ps_v_i[i] && pl_to_ps_ready_o[i]) begin
          l2p_model[i].push_back(pl_to_ps_data_i[i]);
        end
      end
    end
  end

  always @(negedge aclk) begin
    cycle_count++;
    if (cycle_count > MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end else if (dut.u_chk.fail_count != 0) begin
      $display("A protocol assertion in the bound checker failed at %0t", $time);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]         wdata, rdata;
    logic [1:0]          resp, rresp;
    logic [3:0]          strb;
    logic [NUM_CTRL-1:0] new_seen;
    rst_n_i = 1'b0;
    s_axil_awaddr_i = '0;
    s_axil_araddr_i = '0;
    s_axil_awvalid_i = 1'b0;
    s_axil_wvalid_i = 1'b0;
    s_axil_arvalid_i = 1'b0;
    s_axil_wdata_i = '0;
    s_axil_wstrb_i = '0;
    s_axil_bready_i = 1'b0;
    s_axil_rready_i = 1'b0;
    stat_data_i = '0;
    ps_to_pl_yumi_i = '0;
    pl_to_ps_v_i = '0;
    pl_to_ps_data_i = '0;
    yumi_en = 1'b0;
    push_en = 1'b0;
    bg_state = SEED;
    data_state = lcg(SEED ^ 32'h5a5a5a5a);
    b_wait_state = lcg(SEED ^ 32'h0f0f0f0f);
    r_wait_state = lcg(SEED ^ 32'hf0f0f0f0);
    for (int i = 0; i < NUM_CTRL; i++) ctrl_model[i] = '0;
    repeat (3) @(posedge aclk);
    @(negedge aclk);
    rst_n_i = 1'b1;

    // control registers with partial strobes
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < NUM_CTRL; i++) begin
        data_state = lcg(data_state);
        wdata = data_state;
        strb = (round == 0) ? 4'(4'b0101 << (i % 2)) : 4'(i + 3);
        axil_write(reg_addr(2'd0, i), wdata, strb, resp, new_seen);
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) ctrl_model[i][8*b +: 8] = wdata[8*b +: 8];
        end
        expect_eq(resp, RESP_OKAY, "control write bresp");
        expect_eq(new_seen, 32'(1) << i, "ctrl_new_o after write");
        read_expect(reg_addr(2'd0, i), ctrl_model[i], RESP_OKAY);
        expect_eq(ctrl_data_o[i], ctrl_model[i], "ctrl_data_o");
      end
    end

    // status registers
    repeat (2) begin
      for (int i = 0; i < NUM_STAT; i++) begin
        data_state = lcg(data_state);
        stat_data_i[i] = data_state;
      end
      for (int i = 0; i < NUM_STAT; i++) read_expect(reg_addr(2'd1, i), stat_data_i[i], RESP_OKAY);
    end

    // ps-to-pl fifos under random yumi
    yumi_en = 1'b1;
    for (int k = 0; k < 24; k++) begin
      data_state = lcg(data_state);
      // yumi can take the word in the cycle after its handshake
      p2l_model[k % NUM_F].push_back(data_state);
      axil_write(fifo_addr(2'd0, k % NUM_F), data_state, 4'hf, resp, new_seen);
      if (resp != RESP_OKAY) begin
        expect_eq(resp, RESP_SLVERR, "ps-to-pl push bresp");
        void'(p2l_model[k % NUM_F].pop_back());
      end
    end
    while (p2l_pending() != 0) @(negedge aclk);
    yumi_en = 1'b0;
    repeat (2) @(negedge aclk);
    for (int f = 0; f < NUM_F; f++) begin
      for (int n = 0; n <= DEPTH; n++) begin
        read_expect(fifo_addr(2'd1, f), DEPTH - p2l_model[f].size(), RESP_OKAY);
        data_state = lcg(data_state);
        axil_write(fifo_addr(2'd0, f), data_state, 4'hf, resp, new_seen);
        if (n < DEPTH) begin
          expect_eq(resp, RESP_OKAY, "ps-to-pl push bresp");
          p2l_model[f].push_back(data_state);
        end else begin
          expect_eq(resp, RESP_SLVERR, "bresp for push to full fifo");
        end
      end
      read_expect(fifo_addr(2'd1, f), 0, RESP_OKAY);
    end
    yumi_en = 1'b1;
    while (p2l_pending() != 0) @(negedge aclk);
    repeat (2) @(negedge aclk);
    for (int f = 0; f < NUM_F; f++) read_expect(fifo_addr(2'd1, f), DEPTH, RESP_OKAY);

    // pl-to-ps fifos with random pushes
    push_en = 1'b1;
    for (int k = 0; k < 30; k++) begin
      axil_read(fifo_addr(2'd0, k % NUM_F), rdata, resp);
      if (resp == RESP_OKAY) begin
        expect_true(l2p_model[k % NUM_F].size() > 0, "pl-to-ps pop with no word pushed");
        expect_eq(rdata, l2p_model[k % NUM_F].pop_front(), "pl-to-ps pop data");
      end else begin
        expect_eq(resp, RESP_SLVERR, "pl-to-ps pop rresp");
        expect_eq(rdata, 0, "rdata of empty pop");
      end
    end
    push_en = 1'b0;
    repeat (2) @(negedge aclk);
    for (int f = 0; f < NUM_F; f++) begin
      read_expect(fifo_addr(2'd2, f), l2p_model[f].size(), RESP_OKAY);
      while (l2p_model[f].size() > 0) begin
        wdata = l2p_model[f].pop_front();
        read_expect(fifo_addr(2'd0, f), wdata, RESP_OKAY);
      end
      read_expect(fifo_addr(2'd0, f), 0, RESP_SLVERR);
      read_expect(fifo_addr(2'd2, f), 0, RESP_OKAY);
    end

    // unmapped addresses
    read_expect(10'h300, 0, RESP_DECERR);
    write_expect(10'h300, 32'h1234, RESP_DECERR);
    read_expect(reg_addr(2'd0, NUM_CTRL), 0, RESP_DECERR);
    write_expect(reg_addr(2'd0, NUM_CTRL), 32'h55, RESP_DECERR);
    read_expect(reg_addr(2'd1, NUM_STAT), 0, RESP_DECERR);
    write_expect(reg_addr(2'd1, 0), 32'h77, RESP_DECERR);
    read_expect(fifo_addr(2'd0, NUM_F), 0, RESP_DECERR);
    write_expect(fifo_addr(2'd0, NUM_F), 32'h99, RESP_DECERR);
    write_expect(fifo_addr(2'd1, 0), 32'h11, RESP_DECERR);
    write_expect(fifo_addr(2'd2, 1), 32'h22, RESP_DECERR);
    read_expect(fifo_addr(2'd3, 0), 0, RESP_DECERR);
    for (int i = 0; i < NUM_CTRL; i++) expect_eq(ctrl_data_o[i], ctrl_model[i], "ctrl_data_o");

    // write and read issued together where the write goes first
    data_state = lcg(data_state);
    wdata = data_state;
    fork
      axil_write(reg_addr(2'd0, 2), wdata, 4'hf, resp, new_seen);
      axil_read(reg_addr(2'd0, 2), rdata, rresp);
    join
    ctrl_model[2] = wdata;
    expect_eq(resp, RESP_OKAY, "overlapped write bresp");
    expect_eq(rresp, RESP_OKAY, "overlapped read rresp");
    expect_eq(rdata, ctrl_model[2], "overlapped read data");

    @(negedge aclk);
    if (dut.u_chk.fail_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

endmodule

//--- src.f
rtl/zynq_shell_pkg.sv
rtl/shell_access_if.sv
rtl/shell_fifo.sv
rtl/csr_bank.sv
rtl/fifo_bank.sv
rtl/axil_front.sv
rtl/zynq_pl_shell.sv
bench/zynq_pl_shell_chk.sv
bench/tb_zynq_pl_shell.sv

//--- Bender.yml
package:
  name: zynq_pl_shell

sources:
  - rtl/zynq_shell_pkg.sv
  - rtl/shell_access_if.sv
  - rtl/shell_fifo.sv
  - rtl/csr_bank.sv
  - rtl/fifo_bank.sv
  - rtl/axil_front.sv
  - rtl/zynq_pl_shell.sv
  - target: test
    files:
      - bench/zynq_pl_shell_chk.sv
      - bench/tb_zynq_pl_shell.sv
